//--- project.f
+incdir+src
src/deser_data_pkg.sv
src/deser_status_pkg.sv
src/shift_counter.sv
src/serial_parallel.sv
src/word_fifo.sv
src/deser_top.sv
testbench/deser_tb.sv

//--- Makefile
# Verilator build and run for the serial-word receiver

TOP = deser_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --timescale 1ns/10ps -f project.f --top-module deser_top
	verilator --lint-only --timing --timescale 1ns/10ps -f project.f --top-module $(TOP)

sim:
	verilator --binary --timing --timescale 1ns/10ps -f project.f --top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP) > sim.log 2>&1
	cat sim.log
	@if grep -q "Finished with errors" sim.log; then \
		echo "simulation failed"; exit 1; \
	fi
	@echo "simulation passed"

clean:
	rm -rf obj_dir sim.log

//--- testbench/deser_tb.sv
//############################
// deser testbench
// random serial stream against a bit-queue
// model of the converter and the FIFO
//############################

`timescale 1ns/10ps
`default_nettype none

`include "deser_params.svh"

module deser_tb;

    import deser_data_pkg::*;
    import deser_status_pkg::*;

    localparam int DEPTH = `DESER_FIFO_DEPTH;
    localparam int WIDTH = `DESER_WORD_WIDTH;

    logic  clock;
    logic  arst_n;
    logic  clock_enable;
    logic  clear;
    logic  serial_in;
    logic  serial_ready;
    logic  word_valid;
    logic  word_ready;
    word_t word;
    fill_t fill;

    int value_errors;
    int wait_errors;
    int waited;
    int words_before;
    logic [31:0] rng_state;

    // model state, bits of the word in progress and words expected from the FIFO
    logic  bit_q[$];
    word_t fifo_q[$];
    // a finished word waiting in the converter for room in the FIFO
    logic  pending;
    word_t pending_word;
    int    words_out;

    // DUT outputs as seen just before the most recent edge
    logic  seen_serial_ready;
    fill_t seen_fill;

    deser_top dut0 (
        .clock        (clock),
        .arst_n       (arst_n),
        .clock_enable (clock_enable),
        .clear        (clear),
        .serial_in    (serial_in),
        .serial_ready (serial_ready),
        .word_valid   (word_valid),
        .word_ready   (word_ready),
        .word         (word),
        .fill         (fill)
    );

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] value);
        logic [31:0] x;
        x = value;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("ERR %s at %0t: got 0x%h expected 0x%h", name, $time, got, exp);
            value_errors++;
        end
    endtask

    task automatic check_fill(input string name, input fill_t got, input fill_t exp);
        if (got !== exp) begin
            $display("ERR %s at %0t: got 0x%h expected 0x%h", name, $time, got, exp);
            value_errors++;
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("ERR %s at %0t: got 0x%h expected 0x%h", name, $time, got, exp);
            value_errors++;
        end
    endtask

    // one clock cycle, inputs change on the falling edge and the model
    // predicts what the following rising edge will do
    task automatic step(input logic ce, input logic clr, input logic ready);
        logic  exp_push;
        logic  exp_accept;
        word_t packed_word;
        @(negedge clock);
        rng_state    = xorshift32(rng_state);
        clock_enable = ce;
        clear        = clr;
        word_ready   = ready;
        serial_in    = rng_state[7];
        #1;
        seen_serial_ready = serial_ready;
        seen_fill         = fill;
        // the converter hands over only when enabled and the FIFO has room
        exp_push   = pending && ce && (fifo_q.size() < DEPTH);
        exp_accept = ce && (!pending || exp_push);
        check_flag("serial_ready", serial_ready, exp_accept);
        check_flag("word_valid", word_valid, fifo_q.size() != 0);
        check_fill("fill", fill, fill_t'(fifo_q.size()));
        if (fifo_q.size() != 0) begin
            check_word("word", word, fifo_q[0]);
        end
        if (clr) begin
            // clear drops the partial word, the held word and the buffer
            bit_q.delete();
            fifo_q.delete();
            pending = 1'b0;
        end else begin
            if (fifo_q.size() != 0 && ready) begin
                void'(fifo_q.pop_front());
                words_out++;
            end
            if (exp_push) begin
                fifo_q.push_back(pending_word);
                pending = 1'b0;
            end
            if (exp_accept) begin
                bit_q.push_back(serial_in);
            end
            if (bit_q.size() == WIDTH) begin
                // first bit received is the MSB
                packed_word = '0;
                foreach (bit_q[i]) begin
                    packed_word = {packed_word[WIDTH-2:0], bit_q[i]};
                end
                pending_word = packed_word;
                pending      = 1'b1;
                bit_q.delete();
            end
        end
    endtask

    initial begin
        value_errors = 0;
        wait_errors  = 0;
        words_out    = 0;
        pending      = 1'b0;
        pending_word = '0;
        rng_state    = 32'h18ad;
        arst_n       = 1'b0;
        clock_enable = 1'b1;
        clear        = 1'b0;
        serial_in    = 1'b0;
        word_ready   = 1'b0;

        repeat (16) @(posedge clock);
        @(negedge clock);
        arst_n = 1'b1;
        #1;
        check_flag("serial_ready", serial_ready, 1'b1);
        check_flag("word_valid", word_valid, 1'b0);
        check_fill("fill", fill, '0);
        // serial_ready is high at the edge after the release, so that edge takes serial_in
        bit_q.push_back(serial_in);

        // uninterrupted stream with the output always ready
        words_before = words_out;
        repeat (200) step(1'b1, 1'b0, 1'b1);
        if (words_out == words_before) begin
            $display("no word reached the output during the free-running stream");
            wait_errors++;
        end

        // back-pressure until the FIFO is full and the converter holds a word
        waited = 0;
        while (!(seen_fill == fill_t'(DEPTH) && !seen_serial_ready) && waited < 200) begin
            step(1'b1, 1'b0, 1'b0);
            if (seen_fill > fill_t'(DEPTH)) begin
                $display("FIFO fill went past its depth");
                wait_errors++;
            end
            waited++;
        end
        if (waited >= 200) begin
            $display("timed out waiting for the FIFO to fill under back-pressure");
            wait_errors++;
        end
        repeat (20) begin
            step(1'b1, 1'b0, 1'b0);
            check_flag("serial_ready", seen_serial_ready, 1'b0);
        end

        // release the output and let the buffer drain
        waited = 0;
        step(1'b1, 1'b0, 1'b1);
        while (seen_fill != '0 && waited < 100) begin
            step(1'b1, 1'b0, 1'b1);
            waited++;
        end
        if (waited >= 100) begin
            $display("timed out waiting for the FIFO to drain");
            wait_errors++;
        end

        // frozen serial side, the FIFO still drains
        repeat (30) step(1'b1, 1'b0, 1'b0);
        repeat (12) step(1'b0, 1'b0, 1'b1);
        repeat (40) step(1'b1, 1'b0, 1'b1);

        // clear with the converter enabled and with it frozen
        repeat (13) step(1'b1, 1'b0, 1'b0);
        step(1'b1, 1'b1, 1'b0);
        step(1'b1, 1'b0, 1'b0);
        check_fill("fill", seen_fill, '0);
        repeat (21) step(1'b1, 1'b0, 1'b0);
        step(1'b0, 1'b1, 1'b0);
        step(1'b1, 1'b0, 1'b1);
        check_fill("fill", seen_fill, '0);

        // mixed random traffic with occasional stalls, freezes and clears
        repeat (4000) begin
            rng_state = xorshift32(rng_state);
            step(rng_state[7:4] != 4'h0, rng_state[15:9] == 7'h00, rng_state[2:0] != 3'h0);
        end

        $display("value errors: %0d, wait errors: %0d, words checked: %0d",
                 value_errors, wait_errors, words_out);
        if (value_errors == 0 && wait_errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- src/deser_top.sv
//############################
// serial-word receiver top
// converter followed by a word FIFO,
// no logic of its own
//############################

`timescale 1ns/10ps
`default_nettype none

module deser_top (
    input  logic                    clock,
    input  logic                    arst_n,
    input  logic                    clock_enable,
    input  logic                    clear,
    input  logic                    serial_in,
    output logic                    serial_ready,
    output logic                    word_valid,
    input  logic                    word_ready,
    output deser_data_pkg::word_t   word,
    output deser_status_pkg::fill_t fill
);

    import deser_data_pkg::*;

    // converter to FIFO stream
    // conv_ready is the FIFO's not-full, so a full FIFO stalls the serial side
    logic  conv_valid;
    logic  conv_ready;
    word_t conv_word;

    // clock_enable only reaches the converter
    // the FIFO keeps draining while the serial side is frozen
    serial_parallel converter (
        .clock        (clock),
        .arst_n       (arst_n),
        .clock_enable (clock_enable),
        .clear        (clear),
        .serial_in    (serial_in),
        .serial_ready (serial_ready),
        .conv_valid   (conv_valid),
        .conv_ready   (conv_ready),
        .conv_word    (conv_word)
    );

    // clear empties the buffer together with the shift chain
    word_fifo #(
        .payload_t (word_t)
    ) buffer (
        .clock      (clock),
        .arst_n     (arst_n),
        .clear      (clear),
        .push_valid (conv_valid),
        .push_ready (conv_ready),
        .push_data  (conv_word),
        .pop_valid  (word_valid),
        .pop_ready  (word_ready),
        .pop_data   (word),
        .fill       (fill)
    );

endmodule

`default_nettype wire

//--- src/word_fifo.sv
//############################
// word FIFO
// circular buffer of a fixed depth with
// valid/ready ports on both sides
//############################

`timescale 1ns/10ps
`default_nettype none

module word_fifo #(
    parameter type payload_t = logic
) (
    input  logic                    clock,
    input  logic                    arst_n,
    input  logic                    clear,
    input  logic                    push_valid,
    output logic                    push_ready,
    input  payload_t                push_data,
    output logic                    pop_valid,
    input  logic                    pop_ready,
    output payload_t                pop_data,
    output deser_status_pkg::fill_t fill
);

    import deser_status_pkg::*;

    localparam fill_t FILL_EMPTY = '0;
    localparam fill_t FILL_FULL  = fill_t'(FIFO_DEPTH);

    // storage entries, written at the write pointer and read at the read pointer
    payload_t mem [FIFO_DEPTH];

    fifo_ptr_t wr_ptr;
    fifo_ptr_t rd_ptr;

    // transfers on each side
    logic push_done;
    logic pop_done;

    // both flags come from the fill level alone so neither side waits on the other
    always_comb begin
        push_ready = (fill != FILL_FULL);
        pop_valid  = (fill != FILL_EMPTY);
        push_done  = push_valid && push_ready;
        pop_done   = pop_valid && pop_ready;
    end

    // the head entry is always on the output, pop_valid says whether it counts
    always_comb begin
        pop_data = mem[rd_ptr];
    end

    // a written entry appears on the output right after the write edge
    always_ff @(posedge clock) begin
        if (push_done) begin
            mem[wr_ptr] <= push_data;
        end
    end

    // pointers wrap on their own since the depth is a power of two
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else if (clear) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (push_done) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop_done) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    // occupancy moves only when exactly one side transfers
    // a push and a pop on the same edge leave it as it is
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            fill <= FILL_EMPTY;
        end else if (clear) begin
            fill <= FILL_EMPTY;
        end else if (push_done && !pop_done) begin
            fill <= fill + 1'b1;
        end else if (pop_done && !push_done) begin
            fill <= fill - 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- src/serial_parallel.sv
//############################
// serial to parallel converter
// shifts in serial bits MSB first and
// offers each word on a valid/ready port
//############################

`timescale 1ns/10ps
`default_nettype none

module serial_parallel (
    input  logic                 clock,
    input  logic                 arst_n,
    input  logic                 clock_enable,
    input  logic                 clear,
    input  logic                 serial_in,
    output logic                 serial_ready,
    output logic                 conv_valid,
    input  logic                 conv_ready,
    output deser_data_pkg::word_t conv_word
);

    import deser_data_pkg::*;

    localparam bit_count_t COUNT_ZERO = '0;
    // the bit that shifts in on the handshake cycle already belongs to the next word
    localparam bit_count_t COUNT_NEXT = bit_count_t'(WORD_WIDTH - 1);

    // bits still missing from the word in the shift chain
    bit_count_t count;

    // counter controls
    logic counter_run;
    logic counter_load;

    // the output word leaves on this cycle
    logic handshake_done;

    // one more serial bit enters the chain on this cycle
    logic shifter_run;

    // MSB-first shift chain, the oldest bit ends up in the top position
    word_t shift_chain;

    // down counter of the remaining shifts
    // clear restarts it at a full word even with clock_enable low
    shift_counter bits_remaining (
        .clock      (clock),
        .arst_n     (arst_n),
        .clear      (clear),
        .run        (counter_run),
        .load       (counter_load),
        .load_value (COUNT_NEXT),
        .count      (count)
    );

    // the word is complete when no bits remain
    // clock_enable low hides the word and stops all shifting
    always_comb begin
        conv_valid     = (count == COUNT_ZERO) && clock_enable;
        handshake_done = conv_valid && conv_ready;

        // keep counting while bits are missing
        counter_run    = (count != COUNT_ZERO) && clock_enable;
        // a completed handshake reloads, so an unbroken stream needs no gap bit
        counter_load   = handshake_done;

        shifter_run    = counter_run || counter_load;
    end

    // the source may move to its next bit only after a cycle with this high
    always_comb begin
        serial_ready = shifter_run;
    end

    // clear empties the chain, otherwise it shifts when the counter allows it
    // under back-pressure the chain holds the finished word in place
    always_ff @(posedge clock) begin
        if (clear) begin
            shift_chain <= '0;
        end else if (shifter_run) begin
            shift_chain <= {shift_chain[WORD_WIDTH-2:0], serial_in};
        end
    end

    // the chain itself is the parallel word
    always_comb begin
        conv_word = shift_chain;
    end

endmodule

`default_nettype wire

//--- src/shift_counter.sv
//############################
// shift counter
// loadable down counter of the bits
// still missing from the current word
//############################

`timescale 1ns/10ps
`default_nettype none

`include "deser_params.svh"

module shift_counter (
    input  logic                      clock,
    input  logic                      arst_n,
    input  logic                      clear,
    input  logic                      run,
    input  logic                      load,
    input  deser_data_pkg::bit_count_t load_value,
    output deser_data_pkg::bit_count_t count
);

    import deser_data_pkg::*;

    // a fresh word is missing all of its bits
    localparam bit_count_t COUNT_FULL = bit_count_t'(`DESER_WORD_WIDTH);

    // priority is clear, then load, then run
    // clear has to win even when the caller holds run and load low
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            count <= COUNT_FULL;
        end else if (clear) begin
            count <= COUNT_FULL;
        end else if (load) begin
            // load starts the next word while the last one is handed out
            count <= load_value;
        end else if (run) begin
            // the caller drops run once the word is complete
            count <= count - 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- src/deser_status_pkg.sv
//############################
// deser status package
// fill level and pointer types
// of the word FIFO
//############################

`default_nettype none

`include "deser_params.svh"

package deser_status_pkg;

    localparam int unsigned FIFO_DEPTH = `DESER_FIFO_DEPTH;
    // occupancy runs from empty up to and including a full buffer
    localparam int unsigned FILL_WIDTH = $clog2(FIFO_DEPTH + 1);
    // a one-entry buffer still needs a one-bit index
    localparam int unsigned PTR_WIDTH = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;

    typedef logic [FILL_WIDTH-1:0] fill_t;
    typedef logic [PTR_WIDTH-1:0] fifo_ptr_t;

endpackage

`default_nettype wire

//--- src/deser_data_pkg.sv
//############################
// deser data package
// word and bit count types shared
// by the converter and the FIFO
//############################

`default_nettype none

`include "deser_params.svh"

package deser_data_pkg;

    // width of one assembled word
    localparam int unsigned WORD_WIDTH = `DESER_WORD_WIDTH;
    // the count has to hold the full word width, not just width minus one
    localparam int unsigned COUNT_WIDTH = $clog2(WORD_WIDTH + 1);

    typedef logic [WORD_WIDTH-1:0] word_t;
    typedef logic [COUNT_WIDTH-1:0] bit_count_t;

endpackage

`default_nettype wire

//--- src/deser_params.svh
//############################
// deser parameters
// word width and FIFO depth of the
// serial-word receiver
//############################

`ifndef DESER_PARAMS_SVH
`define DESER_PARAMS_SVH

// bits per received word, shifted in MSB first
`define DESER_WORD_WIDTH 8

// words held by the output FIFO, kept to a power of two so the pointers wrap on their own
`define DESER_FIFO_DEPTH 4

`endif
